//--- list.f
rtl/memPkg.sv
rtl/instrCache.sv
rtl/dataCache.sv
rtl/busArbiter.sv
rtl/busMemory.sv
rtl/memSys.sv
test/memSys_chk.sv
test/memSysTb.sv

//--- rtl/busArbiter.sv
`timescale 1ns/100ps

module busArbiter (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         reqF,
  input  logic [memPkg::AddrWidth-1:0] addrF,
  input  logic                         reqM,
  input  logic [memPkg::AddrWidth-1:0] addrM,
  input  logic                         writeM,
  input  logic [memPkg::DataWidth-1:0] wDataM,
  input  logic [memPkg::SizeWidth-1:0] sizeM,
  input  logic                         hReady,
  output logic                         hRequest,
  output logic [memPkg::AddrWidth-1:0] hAddr,
  output logic                         hWrite,
  output logic [memPkg::DataWidth-1:0] hWData,
  output logic [memPkg::SizeWidth-1:0] hSize,
  output logic                         readyF,
  output logic                         readyM
);

  logic busy;
  logic ownerData;
  logic selData;

  // Idle bus routes straight away, data side wins a tie
  assign selData = busy ? ownerData : reqM;

  assign hRequest = busy || reqF || reqM;
  assign hAddr    = selData ? addrM : addrF;
  assign hWrite   = selData && writeM;
  assign hWData   = wDataM;
  assign hSize    = selData ? sizeM : memPkg::SizeWord;

  // Ready goes to the owner only
  assign readyF = hReady && !selData;
  assign readyM = hReady && selData;

  // Owner is latched on the first request cycle and held to hReady
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy      <= 1'b0;
      ownerData <= 1'b0;
    end else if (hReady) begin
      busy <= 1'b0;
    end else if (!busy && (reqF || reqM)) begin
      busy      <= 1'b1;
      ownerData <= reqM;
    end
  end

endmodule

//--- rtl/busMemory.sv
`timescale 1ns/100ps

module busMemory (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         hRequest,
  input  logic [memPkg::AddrWidth-1:0] hAddr,
  input  logic                         hWrite,
  input  logic [memPkg::DataWidth-1:0] hWData,
  input  logic [memPkg::SizeWidth-1:0] hSize,
  output logic [memPkg::DataWidth-1:0] hRData,
  output logic                         hReady
);

  logic [memPkg::DataWidth-1:0]    mem [memPkg::MemWords];
  logic [memPkg::MemIndexBits-1:0] wordIdx;
  logic [memPkg::MemIndexBits-1:0] fillCnt;
  logic                            filling;
  logic [memPkg::WaitCntBits-1:0]  waitCnt;
  logic [memPkg::ByteLanes-1:0]    laneEn;

  // Upper address bits are ignored
  assign wordIdx = hAddr[memPkg::MemIndexBits+1:2];
  assign hRData  = mem[wordIdx];

  // Ready on the cycle after the wait states run out
  assign hReady = hRequest && !filling && (waitCnt == memPkg::MemWaitStates + 1);

  always_comb begin
    laneEn = '0;
    case (hSize)
      memPkg::SizeByte: begin
        laneEn[hAddr[1:0]] = 1'b1;
      end
      memPkg::SizeHalf: begin
        laneEn[{hAddr[1], 1'b0}] = 1'b1;
        laneEn[{hAddr[1], 1'b1}] = 1'b1;
      end
      default: laneEn = '1;
    endcase
  end

  // Reset restarts the fill, one word per cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      filling <= 1'b1;
      fillCnt <= '0;
      waitCnt <= '0;
    end else begin
      if (filling) begin
        fillCnt <= fillCnt + 1'b1;
        if (&fillCnt) begin
          filling <= 1'b0;
        end
      end
      if (hReady) begin
        waitCnt <= '0;
      end else if (hRequest && !filling) begin
        waitCnt <= waitCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstN && filling) begin
      mem[fillCnt] <= memPkg::DataWidth'(fillCnt) ^ memPkg::MemFillKey;
    end else if (hReady && hWrite) begin
      for (int i = 0; i < memPkg::ByteLanes; i++) begin
        if (laneEn[i]) begin
          mem[wordIdx][8*i +: 8] <= hWData[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- rtl/dataCache.sv
`timescale 1ns/100ps

module dataCache (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [memPkg::AddrWidth-1:0] dataAdrM,
  input  logic [memPkg::DataWidth-1:0] writeDataM,
  input  logic [memPkg::ByteLanes-1:0] byteMaskM,
  input  logic                         memWriteM,
  input  logic                         memToRegM,
  input  logic                         dCacheEn,
  input  logic                         dInvalidate,
  input  logic                         readyM,
  input  logic [memPkg::DataWidth-1:0] hRData,
  output logic [memPkg::DataWidth-1:0] readDataM,
  output logic                         dStall,
  output logic                         reqM,
  output logic [memPkg::AddrWidth-1:0] addrM,
  output logic                         writeM,
  output logic [memPkg::DataWidth-1:0] wDataM,
  output logic [memPkg::SizeWidth-1:0] sizeM
);

  logic [memPkg::CacheTagBits-1:0]   tagArr  [memPkg::CacheLines];
  logic [memPkg::DataWidth-1:0]      dataArr [memPkg::CacheLines];
  logic [memPkg::CacheLines-1:0]     validArr;
  logic [memPkg::CacheIndexBits-1:0] index;
  logic [memPkg::CacheTagBits-1:0]   tag;
  logic                              tagMatch;
  logic                              loadHit;
  logic                              fillDone;
  logic [memPkg::DataWidth-1:0]      fillData;
  logic [memPkg::SizeWidth-1:0]      storeSize;
  logic [1:0]                        laneOff;

  assign index = dataAdrM[memPkg::CacheIndexBits+1:2];
  assign tag   = dataAdrM[memPkg::AddrWidth-1:memPkg::CacheIndexBits+2];

  assign tagMatch = validArr[index] && (tagArr[index] == tag);
  assign loadHit  = dCacheEn && memToRegM && !memWriteM && tagMatch;

  // Stores are write-through and always wait for the bus
  always_comb begin
    if (memWriteM) begin
      dStall = !fillDone;
    end else begin
      dStall = memToRegM && !loadHit && !fillDone;
    end
  end

  assign reqM      = dStall;
  assign readDataM = fillDone ? fillData : dataArr[index];

  // Mask to size code and lane offset of the first enabled byte
  always_comb begin
    case (byteMaskM)
      4'b0001: begin
        storeSize = memPkg::SizeByte;
        laneOff   = 2'd0;
      end
      4'b0010: begin
        storeSize = memPkg::SizeByte;
        laneOff   = 2'd1;
      end
      4'b0100: begin
        storeSize = memPkg::SizeByte;
        laneOff   = 2'd2;
      end
      4'b1000: begin
        storeSize = memPkg::SizeByte;
        laneOff   = 2'd3;
      end
      4'b0011: begin
        storeSize = memPkg::SizeHalf;
        laneOff   = 2'd0;
      end
      4'b1100: begin
        storeSize = memPkg::SizeHalf;
        laneOff   = 2'd2;
      end
      default: begin
        storeSize = memPkg::SizeWord;
        laneOff   = 2'd0;
      end
    endcase
  end

  // Store data already sits in its own byte lanes
  assign writeM = memWriteM;
  assign wDataM = writeDataM;
  assign sizeM  = memWriteM ? storeSize : memPkg::SizeWord;
  assign addrM  = {dataAdrM[memPkg::AddrWidth-1:2], memWriteM ? laneOff : 2'b00};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fillDone <= 1'b0;
    end else begin
      fillDone <= readyM;
    end
  end

  always_ff @(posedge clk) begin
    if (readyM && !memWriteM) begin
      fillData <= hRData;
    end
  end

  // Only load fills allocate
  always_ff @(posedge clk) begin
    if (!rstN || dInvalidate) begin
      validArr <= '0;
    end else if (readyM && dCacheEn && !memWriteM) begin
      validArr[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (readyM && dCacheEn) begin
      if (!memWriteM) begin
        tagArr[index]  <= tag;
        dataArr[index] <= hRData;
      end else if (tagMatch) begin
        // Merge store bytes into the resident line
        for (int i = 0; i < memPkg::ByteLanes; i++) begin
          if (byteMaskM[i]) begin
            dataArr[index][8*i +: 8] <= writeDataM[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

//--- rtl/instrCache.sv
`timescale 1ns/100ps

module instrCache (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [memPkg::AddrWidth-1:0] pcF,
  input  logic                         iCacheEn,
  input  logic                         iInvalidate,
  input  logic                         readyF,
  input  logic [memPkg::DataWidth-1:0] hRData,
  output logic [memPkg::DataWidth-1:0] instrF,
  output logic                         iStall,
  output logic                         reqF,
  output logic [memPkg::AddrWidth-1:0] addrF
);

  logic [memPkg::CacheTagBits-1:0]   tagArr  [memPkg::CacheLines];
  logic [memPkg::DataWidth-1:0]      dataArr [memPkg::CacheLines];
  logic [memPkg::CacheLines-1:0]     validArr;
  logic [memPkg::CacheIndexBits-1:0] index;
  logic [memPkg::CacheTagBits-1:0]   tag;
  logic                              hit;
  logic                              fillDone;
  logic [memPkg::DataWidth-1:0]      fillData;

  assign index = pcF[memPkg::CacheIndexBits+1:2];
  assign tag   = pcF[memPkg::AddrWidth-1:memPkg::CacheIndexBits+2];

  // A disabled cache never hits, so every fetch goes to the bus
  assign hit = iCacheEn && validArr[index] && (tagArr[index] == tag);

  assign iStall = !hit && !fillDone;
  assign reqF   = iStall;
  assign addrF  = {pcF[memPkg::AddrWidth-1:2], 2'b00};

  // Bus data wins for one cycle after the fill, which also serves bypass
  assign instrF = fillDone ? fillData : dataArr[index];

  // Set for exactly the cycle after readyF
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fillDone <= 1'b0;
    end else begin
      fillDone <= readyF;
    end
  end

  always_ff @(posedge clk) begin
    if (readyF) begin
      fillData <= hRData;
    end
  end

  // Invalidate pulse drops every line at the next edge
  always_ff @(posedge clk) begin
    if (!rstN || iInvalidate) begin
      validArr <= '0;
    end else if (readyF && iCacheEn) begin
      validArr[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (readyF && iCacheEn) begin
      tagArr[index]  <= tag;
      dataArr[index] <= hRData;
    end
  end

endmodule

//--- rtl/memPkg.sv
package memPkg;

  // Word and bus widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int ByteLanes = DataWidth / 8;
  localparam int SizeWidth = 3;

  // Cache geometry, one word per line
  // Index is address bits 5..2, tag is the rest above it
  localparam int CacheIndexBits = 4;
  localparam int CacheLines     = 1 << CacheIndexBits;
  localparam int CacheTagBits   = AddrWidth - CacheIndexBits - 2;

  // Backing memory, word indexed by address bits 11..2
  localparam int MemIndexBits = 10;
  localparam int MemWords     = 1 << MemIndexBits;

  // Idle cycles between request accept and the ready pulse
  localparam int MemWaitStates = 2;
  localparam int WaitCntBits   = $clog2(MemWaitStates + 2);

  // Power-up pattern, each word is its index XOR this key
  localparam logic [DataWidth-1:0] MemFillKey = 32'h5A3C_96E1;

  // Bus transfer size codes
  localparam logic [SizeWidth-1:0] SizeByte = 3'd0;
  localparam logic [SizeWidth-1:0] SizeHalf = 3'd1;
  localparam logic [SizeWidth-1:0] SizeWord = 3'd2;

endpackage

//--- rtl/memSys.sv
`timescale 1ns/100ps

module memSys (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [memPkg::AddrWidth-1:0] pcF,
  input  logic                         iCacheEn,
  input  logic                         iInvalidate,
  output logic [memPkg::DataWidth-1:0] instrF,
  output logic                         iStall,
  input  logic [memPkg::AddrWidth-1:0] dataAdrM,
  input  logic [memPkg::DataWidth-1:0] writeDataM,
  input  logic [memPkg::ByteLanes-1:0] byteMaskM,
  input  logic                         memWriteM,
  input  logic                         memToRegM,
  input  logic                         dCacheEn,
  input  logic                         dInvalidate,
  output logic [memPkg::DataWidth-1:0] readDataM,
  output logic                         dStall
);

  // Cache to arbiter
  logic                         reqF;
  logic [memPkg::AddrWidth-1:0] addrF;
  logic                         readyF;
  logic                         reqM;
  logic [memPkg::AddrWidth-1:0] addrM;
  logic                         writeM;
  logic [memPkg::DataWidth-1:0] wDataM;
  logic [memPkg::SizeWidth-1:0] sizeM;
  logic                         readyM;

  // Shared bus
  logic                         hRequest;
  logic [memPkg::AddrWidth-1:0] hAddr;
  logic                         hWrite;
  logic [memPkg::DataWidth-1:0] hWData;
  logic [memPkg::SizeWidth-1:0] hSize;
  logic [memPkg::DataWidth-1:0] hRData;
  logic                         hReady;

  instrCache u_instrCache (
    .clk        (clk        ),
    .rstN       (rstN       ),
    .pcF        (pcF        ),
    .iCacheEn   (iCacheEn   ),
    .iInvalidate(iInvalidate),
    .readyF     (readyF     ),
    .hRData     (hRData     ),
    .instrF     (instrF     ),
    .iStall     (iStall     ),
    .reqF       (reqF       ),
    .addrF      (addrF      )
  );

  dataCache u_dataCache (
    .clk        (clk        ),
    .rstN       (rstN       ),
    .dataAdrM   (dataAdrM   ),
    .writeDataM (writeDataM ),
    .byteMaskM  (byteMaskM  ),
    .memWriteM  (memWriteM  ),
    .memToRegM  (memToRegM  ),
    .dCacheEn   (dCacheEn   ),
    .dInvalidate(dInvalidate),
    .readyM     (readyM     ),
    .hRData     (hRData     ),
    .readDataM  (readDataM  ),
    .dStall     (dStall     ),
    .reqM       (reqM       ),
    .addrM      (addrM      ),
    .writeM     (writeM     ),
    .wDataM     (wDataM     ),
    .sizeM      (sizeM      )
  );

  busArbiter u_busArbiter (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .reqF    (reqF    ),
    .addrF   (addrF   ),
    .reqM    (reqM    ),
    .addrM   (addrM   ),
    .writeM  (writeM  ),
    .wDataM  (wDataM  ),
    .sizeM   (sizeM   ),
    .hReady  (hReady  ),
    .hRequest(hRequest),
    .hAddr   (hAddr   ),
    .hWrite  (hWrite  ),
    .hWData  (hWData  ),
    .hSize   (hSize   ),
    .readyF  (readyF  ),
    .readyM  (readyM  )
  );

  busMemory u_busMemory (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .hRequest(hRequest),
    .hAddr   (hAddr   ),
    .hWrite  (hWrite  ),
    .hWData  (hWData  ),
    .hSize   (hSize   ),
    .hRData  (hRData  ),
    .hReady  (hReady  )
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module memSysTb -o memSysSim

./obj_dir/memSysSim

//--- test/memSysTb.sv
`timescale 1ns/100ps

module memSysTb;

  // Reset and memory fill take about 1100 cycles, the tests a few thousand at most
  localparam int TimeoutCycles = 20000;

  logic                         clk;
  logic                         rstN;
  logic [memPkg::AddrWidth-1:0] pcF;
  logic                         iCacheEn;
  logic                         iInvalidate;
  logic [memPkg::DataWidth-1:0] instrF;
  logic                         iStall;
  logic [memPkg::AddrWidth-1:0] dataAdrM;
  logic [memPkg::DataWidth-1:0] writeDataM;
  logic [memPkg::ByteLanes-1:0] byteMaskM;
  logic                         memWriteM;
  logic                         memToRegM;
  logic                         dCacheEn;
  logic                         dInvalidate;
  logic [memPkg::DataWidth-1:0] readDataM;
  logic                         dStall;

  // Expected memory contents, word indexed like the bus memory
  logic [memPkg::DataWidth-1:0] refMem [1 << memPkg::MemIndexBits];
  int unsigned                  cycles = 0;

  memSys u_memSys (.*);

  bind memSys memSys_chk u_memSysChk (
    .clk(clk), .rstN(rstN), .hRequest(hRequest), .hReady(hReady),
    .hAddr(hAddr), .hWrite(hWrite), .reqF(reqF), .reqM(reqM)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      failRun("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkVal(input string test, input logic [memPkg::DataWidth-1:0] exp,
                          input logic [memPkg::DataWidth-1:0] act);
    assert (act === exp) else begin
      failRun($sformatf("FAIL %s expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic checkTrue(input logic cond, input string why);
    assert (cond) else begin
      failRun(why);
    end
  endtask

  // All access tasks start and end 1 ns after a rising edge
  task automatic fetchCheck(input string test, input logic [memPkg::AddrWidth-1:0] addr,
                            output int stalls);
    pcF    = addr;
    stalls = 0;
    @(negedge clk);
    while (iStall) begin
      stalls++;
      @(negedge clk);
    end
    checkVal(test, refMem[addr[memPkg::MemIndexBits+1:2]], instrF);
    @(posedge clk);
    #1;
  endtask

  task automatic dataAccess(input logic [memPkg::AddrWidth-1:0] addr,
                            input logic [memPkg::DataWidth-1:0] wdata,
                            input logic [memPkg::ByteLanes-1:0] mask, input logic write,
                            output logic [memPkg::DataWidth-1:0] data, output int stalls);
    dataAdrM   = addr;
    writeDataM = wdata;
    byteMaskM  = mask;
    memWriteM  = write;
    memToRegM  = !write;
    stalls     = 0;
    @(negedge clk);
    while (dStall) begin
      stalls++;
      @(negedge clk);
    end
    data = readDataM;
    @(posedge clk);
    #1;
    memWriteM = 1'b0;
    memToRegM = 1'b0;
  endtask

  task automatic loadCheck(input string test, input logic [memPkg::AddrWidth-1:0] addr,
                           output int stalls);
    logic [memPkg::DataWidth-1:0] data;
    dataAccess(addr, '0, 4'b1111, 1'b0, data, stalls);
    checkVal(test, refMem[addr[memPkg::MemIndexBits+1:2]], data);
  endtask

  // Store data already sits in its own byte lanes
  task automatic store(input logic [memPkg::AddrWidth-1:0] addr,
                       input logic [memPkg::DataWidth-1:0] wdata,
                       input logic [memPkg::ByteLanes-1:0] mask);
    logic [memPkg::DataWidth-1:0] readBack;
    int                           stalls;
    dataAccess(addr, wdata, mask, 1'b1, readBack, stalls);
    checkTrue(stalls > 0, "Stores and loads: a store finished without a bus write");
    for (int i = 0; i < memPkg::ByteLanes; i++) begin
      if (mask[i]) begin
        refMem[addr[memPkg::MemIndexBits+1:2]][8*i +: 8] = wdata[8*i +: 8];
      end
    end
  endtask

  task automatic pulseInvalidate(input logic instrSide);
    iInvalidate = instrSide;
    dInvalidate = !instrSide;
    @(posedge clk);
    #1;
    iInvalidate = 1'b0;
    dInvalidate = 1'b0;
  endtask

  // Byte, aligned half or full word
  function automatic logic [memPkg::ByteLanes-1:0] randomMask();
    int unsigned kind;
    kind = $urandom_range(2, 0);
    if (kind == 0) begin
      return 4'b0001 << $urandom_range(3, 0);
    end else if (kind == 1) begin
      return ($urandom_range(1, 0) == 1) ? 4'b1100 : 4'b0011;
    end
    return 4'b1111;
  endfunction

  task automatic fetchMissHit();
    int stalls;
    fetchCheck("fetch miss then hit", 32'h0000_08A4, stalls);
    checkTrue(stalls > 0, "Fetch miss then hit: the first fetch did not stall");
    fetchCheck("fetch miss then hit", 32'h0000_08A4, stalls);
    checkTrue(stalls == 0, "Fetch miss then hit: the repeated fetch stalled");
  endtask

  task automatic storeLoadMix();
    int                           stalls;
    logic [memPkg::AddrWidth-1:0] addr;
    // Resident line takes the merged bytes and keeps hitting
    loadCheck("stores and loads", 32'h0000_0010, stalls);
    store(32'h0000_0010, $urandom(), randomMask());
    loadCheck("stores and loads", 32'h0000_0010, stalls);
    checkTrue(stalls == 0, "Stores and loads: a resident line missed after a store");
    store(32'h0000_002C, $urandom(), randomMask());
    loadCheck("stores and loads", 32'h0000_002C, stalls);
    checkTrue(stalls > 0, "Stores and loads: a store allocated a missing line");
    repeat (40) begin
      addr = 32'($urandom_range(63, 0)) << 2;
      if ($urandom_range(1, 0) == 1) begin
        loadCheck("stores and loads", addr, stalls);
      end
      store(addr, $urandom(), randomMask());
      loadCheck("stores and loads", addr, stalls);
    end
  endtask

  // Same index, different tags
  task automatic conflictEviction();
    int stalls;
    repeat (4) begin
      loadCheck("conflict eviction", 32'h0000_0100, stalls);
      checkTrue(stalls > 0, "Conflict eviction: an evicted data line still hit");
      loadCheck("conflict eviction", 32'h0000_0140, stalls);
      checkTrue(stalls > 0, "Conflict eviction: an evicted data line still hit");
      fetchCheck("conflict eviction", 32'h0000_0900, stalls);
      checkTrue(stalls > 0, "Conflict eviction: an evicted instruction line still hit");
      fetchCheck("conflict eviction", 32'h0000_0940, stalls);
      checkTrue(stalls > 0, "Conflict eviction: an evicted instruction line still hit");
    end
  endtask

  task automatic concurrentMisses();
    int stallsF;
    int stallsD;
    fork
      fetchCheck("concurrent misses", 32'h0000_0A08, stallsF);
      loadCheck("concurrent misses", 32'h0000_0308, stallsD);
    join
    checkTrue(stallsF > 0 && stallsD > 0, "Concurrent misses: an access did not miss");
    checkTrue(stallsD <= stallsF, "Concurrent misses: dStall fell after iStall");
  endtask

  task automatic disableInvalidate();
    int stalls;
    loadCheck("disable and invalidate", 32'h0000_0024, stalls);
    loadCheck("disable and invalidate", 32'h0000_0024, stalls);
    checkTrue(stalls == 0, "Disable and invalidate: an enabled load did not hit");
    dCacheEn = 1'b0;
    repeat (3) begin
      loadCheck("disable and invalidate", 32'h0000_0024, stalls);
      checkTrue(stalls > 0, "Disable and invalidate: the disabled data cache hit");
    end
    dCacheEn = 1'b1;
    pulseInvalidate(1'b0);
    loadCheck("disable and invalidate", 32'h0000_0024, stalls);
    checkTrue(stalls > 0, "Disable and invalidate: a load hit after invalidate");
    fetchCheck("disable and invalidate", 32'h0000_0B30, stalls);
    iCacheEn = 1'b0;
    repeat (3) begin
      fetchCheck("disable and invalidate", 32'h0000_0B30, stalls);
      checkTrue(stalls > 0, "Disable and invalidate: the disabled instruction cache hit");
    end
    // Bypassed fetch must not be stored
    fetchCheck("disable and invalidate", 32'h0000_0B74, stalls);
    iCacheEn = 1'b1;
    fetchCheck("disable and invalidate", 32'h0000_0B74, stalls);
    checkTrue(stalls > 0, "Disable and invalidate: a bypassed fetch was stored");
    fetchCheck("disable and invalidate", 32'h0000_0B30, stalls);
    checkTrue(stalls == 0, "Disable and invalidate: a resident fetch missed");
    pulseInvalidate(1'b1);
    fetchCheck("disable and invalidate", 32'h0000_0B30, stalls);
    checkTrue(stalls > 0, "Disable and invalidate: a fetch hit after invalidate");
  endtask

  initial begin
    void'($urandom(66557));
    rstN        = 1'b0;
    pcF         = 32'h0000_0800;
    iCacheEn    = 1'b1;
    iInvalidate = 1'b0;
    dataAdrM    = '0;
    writeDataM  = '0;
    byteMaskM   = 4'b1111;
    memWriteM   = 1'b0;
    memToRegM   = 1'b0;
    dCacheEn    = 1'b1;
    dInvalidate = 1'b0;
    for (int i = 0; i < (1 << memPkg::MemIndexBits); i++) begin
      refMem[i] = memPkg::DataWidth'(i) ^ memPkg::MemFillKey;
    end
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    // Memory fills one word per cycle before it answers
    repeat (1100) @(posedge clk);
    #1;
    fetchMissHit();
    storeLoadMix();
    conflictEviction();
    concurrentMisses();
    disableInvalidate();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- test/memSys_chk.sv
`timescale 1ns/100ps

module memSys_chk (
  input logic                         clk,
  input logic                         rstN,
  input logic                         hRequest,
  input logic                         hReady,
  input logic [memPkg::AddrWidth-1:0] hAddr,
  input logic                         hWrite,
  input logic                         reqF,
  input logic                         reqM
);

  // Ready answers a request that was already open, and lasts one cycle
  readyInRequest: assert property (
    @(posedge clk) disable iff (!rstN)
      hReady |-> hRequest && $past(hRequest) && !$past(hReady)
  ) else $error("hReady pulsed outside an open request or for more than one cycle");

  // Address holds until the slave answers
  addrHeld: assert property (
    @(posedge clk) disable iff (!rstN) (hRequest && !hReady) |=> $stable(hAddr)
  ) else $error("hAddr changed during an open request");

  // Fetch side alone never writes
  fetchNoWrite: assert property (
    @(posedge clk) disable iff (!rstN) (reqF && !reqM) |-> !hWrite
  ) else $error("bus write while only the fetch side requests");

endmodule
